// File: hw/icache_pkg.sv
package icache_pkg;

	////////////////////////////////////////////////////////////
	// cache geometry
	////////////////////////////////////////////////////////////

	localparam int num_ways = 4;
	localparam int num_sets = 64;
	localparam int line_words = 4;

	// an address splits into tag [31:10], index [9:4] and byte offset [3:0]
	typedef logic [31:0] addr_t;
	typedef logic [21:0] tag_t;
	typedef logic [5:0] index_t;
	typedef logic [31:0] word_t;
	typedef logic [127:0] line_t;
	typedef logic [3:0] way_mask_t;

	////////////////////////////////////////////////////////////
	// state machines
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		ctrl_idle,
		ctrl_lookup,
		ctrl_refill,
		ctrl_bypass,
		ctrl_hold
	} ctrl_state_t;

	typedef enum logic [1:0] {
		rf_idle,
		rf_addr,
		rf_data
	} refill_state_t;

	// configuration register map
	localparam addr_t csr_ctrl_off = 32'h0;
	localparam addr_t csr_hit_off = 32'h4;
	localparam addr_t csr_miss_off = 32'h8;

	localparam int ctrl_enable_bit = 0;
	localparam int ctrl_inval_bit = 1;

endpackage

// File: hw/icache_data_sram.sv
module icache_data_sram
	import icache_pkg::*;
(
	input logic clk,
	input logic en,
	input logic we,
	input index_t index,
	input line_t wdata,
	output line_t rdata
);

	line_t mem [num_sets];

	// a write does not update the read port, which keeps its last read
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wdata;
			end else begin
				rdata <= mem[index];
			end
		end
	end

endmodule

// File: hw/icache_tag_array.sv
module icache_tag_array
	import icache_pkg::*;
(
	input logic clk,
	input logic rst,
	input index_t lookup_index,
	input tag_t lookup_tag,
	input logic alloc,
	input logic inval_pulse,
	output way_mask_t way_hit,
	output way_mask_t victim
);

	tag_t tags [num_ways][num_sets];
	logic [num_sets-1:0] valid_bits [num_ways];
	way_mask_t ring;

	assign victim = ring;

	// all four ways are compared in parallel against the same index
	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			way_hit[w] = valid_bits[w][lookup_index] && (tags[w][lookup_index] == lookup_tag);
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < num_ways; w++) begin
			if (alloc && ring[w]) begin
				tags[w][lookup_index] <= lookup_tag;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// valid bits and victim ring
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			ring <= 4'b0001;
			for (int w = 0; w < num_ways; w++) begin
				valid_bits[w] <= '0;
			end
		end else begin
			// the ring moves one way per fill so replacement is round robin
			if (alloc) begin
				ring <= {ring[num_ways-2:0], ring[num_ways-1]};
			end
			for (int w = 0; w < num_ways; w++) begin
				if (inval_pulse) begin
					valid_bits[w] <= '0;
				end else if (alloc && ring[w]) begin
					valid_bits[w][lookup_index] <= 1'b1;
				end
			end
		end
	end

	// a line is only ever filled into one way, so two ways never match
	a_way_hit_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(way_hit));

endmodule

// File: hw/icache_refill.sv
module icache_refill
	import icache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic refill_start,
	input addr_t refill_addr,
	input logic refill_line_mode,
	output logic refill_done,
	output line_t refill_line,
	output word_t refill_word,
	output addr_t m_araddr,
	output logic m_arvalid,
	input logic m_arready,
	input word_t m_rdata,
	input logic [1:0] m_rresp,
	input logic m_rvalid,
	output logic m_rready
);

	refill_state_t state;
	logic line_mode;
	logic [1:0] beat;
	logic last_beat;

	assign m_arvalid = (state == rf_addr);
	assign m_rready = (state == rf_data);
	assign last_beat = !line_mode || (beat == 2'(line_words - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rf_idle;
			refill_done <= 1'b0;
		end else begin
			refill_done <= 1'b0;
			case (state)
				rf_idle: begin
					if (refill_start) begin
						state <= rf_addr;
					end
				end
				rf_addr: begin
					if (m_arready) begin
						state <= rf_data;
					end
				end
				rf_data: begin
					if (m_rvalid) begin
						state <= last_beat ? rf_idle : rf_addr;
						refill_done <= last_beat;
					end
				end
				default: state <= rf_idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// address sequencing and line assembly
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == rf_idle && refill_start) begin
			line_mode <= refill_line_mode;
			beat <= '0;
			// a line always starts at its base, a single word at its own address
			if (refill_line_mode) begin
				m_araddr <= {refill_addr[31:4], 4'b0000};
			end else begin
				m_araddr <= {refill_addr[31:2], 2'b00};
			end
		end
		if (state == rf_data && m_rvalid) begin
			refill_line[{beat, 5'b00000} +: 32] <= m_rdata;
			refill_word <= m_rdata;
			beat <= beat + 2'd1;
			m_araddr <= m_araddr + 32'd4;
		end
	end

	a_ar_stable: assert property (@(posedge clk) disable iff (rst)
		m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr));

	// the controller waits for refill_done before it can issue another start
	a_start_idle: assert property (@(posedge clk) disable iff (rst)
		refill_start |-> state == rf_idle);

	a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
		m_rvalid && m_rready |-> m_rresp == 2'b00);

endmodule

// File: hw/icache_ctrl.sv
module icache_ctrl
	import icache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic fetch_valid,
	input addr_t fetch_addr,
	output logic fetch_ready,
	output logic rsp_valid,
	output word_t rsp_inst,
	input logic rsp_ready,
	input logic cache_enable,
	output index_t lookup_index,
	output tag_t lookup_tag,
	input way_mask_t way_hit,
	input way_mask_t victim,
	output logic alloc,
	output way_mask_t sram_en,
	output logic sram_we,
	input line_t sram_rdata0,
	input line_t sram_rdata1,
	input line_t sram_rdata2,
	input line_t sram_rdata3,
	output logic refill_start,
	output addr_t refill_addr,
	output logic refill_line_mode,
	input logic refill_done,
	input line_t refill_line,
	input word_t refill_word,
	output logic hit_event,
	output logic miss_event
);

	ctrl_state_t state, state_next;
	logic live;
	addr_t req_addr;
	way_mask_t hit_way;
	logic req_bypass;
	logic rsp_free;
	logic accept;
	logic is_hit;
	logic load_rsp;
	addr_t lookup_addr;
	line_t line_sel;
	word_t result_word;

	// the response slot frees up on the same edge it is consumed
	assign rsp_free = !rsp_valid || rsp_ready;
	assign fetch_ready = live && rsp_free && (state == ctrl_idle || state == ctrl_lookup);
	assign accept = fetch_valid && fetch_ready;
	assign is_hit = cache_enable && (way_hit != '0);

	// during a refill the tag array must see the missing address for the fill
	assign lookup_addr = (state == ctrl_refill) ? req_addr : fetch_addr;
	assign lookup_index = lookup_addr[9:4];
	assign lookup_tag = lookup_addr[31:10];

	assign hit_event = accept && is_hit;
	assign miss_event = accept && cache_enable && !is_hit;
	assign refill_start = accept && !is_hit;
	assign refill_addr = fetch_addr;
	assign refill_line_mode = cache_enable;

	always_comb begin
		sram_en = '0;
		sram_we = 1'b0;
		alloc = 1'b0;
		if (accept && cache_enable) begin
			sram_en = way_hit;
		end
		if (state == ctrl_refill && refill_done) begin
			sram_en = victim;
			sram_we = 1'b1;
			alloc = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// word select
	////////////////////////////////////////////////////////////

	// a miss has no hit way, so it falls through to the refill line
	always_comb begin
		case (hit_way)
			4'b0001: line_sel = sram_rdata0;
			4'b0010: line_sel = sram_rdata1;
			4'b0100: line_sel = sram_rdata2;
			4'b1000: line_sel = sram_rdata3;
			default: line_sel = refill_line;
		endcase
	end

	assign result_word = req_bypass ? refill_word : line_sel[{req_addr[3:2], 5'b00000} +: 32];
	assign load_rsp = rsp_free && (state == ctrl_lookup || state == ctrl_hold ||
		((state == ctrl_refill || state == ctrl_bypass) && refill_done));

	always_comb begin
		state_next = state;
		case (state)
			ctrl_idle, ctrl_lookup: begin
				if (accept) begin
					if (!cache_enable) begin
						state_next = ctrl_bypass;
					end else if (is_hit) begin
						state_next = ctrl_lookup;
					end else begin
						state_next = ctrl_refill;
					end
				end else if (rsp_free) begin
					state_next = ctrl_idle;
				end
			end
			ctrl_refill, ctrl_bypass: begin
				if (refill_done) begin
					state_next = rsp_free ? ctrl_idle : ctrl_hold;
				end
			end
			ctrl_hold: begin
				if (rsp_free) begin
					state_next = ctrl_idle;
				end
			end
			default: state_next = ctrl_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ctrl_idle;
			live <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			state <= state_next;
			live <= 1'b1;
			if (load_rsp) begin
				rsp_valid <= 1'b1;
			end else if (rsp_ready) begin
				rsp_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= fetch_addr;
			hit_way <= cache_enable ? way_hit : '0;
			req_bypass <= !cache_enable;
		end
		if (load_rsp) begin
			rsp_inst <= result_word;
		end
	end

	a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_inst));

endmodule

// File: hw/icache_csr.sv
module icache_csr
	import icache_pkg::*;
(
	input logic clk,
	input logic rst,
	input addr_t s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input word_t s_wdata,
	input logic [3:0] s_wstrb,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input addr_t s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output word_t s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,
	output logic cache_enable,
	output logic inval_pulse,
	input logic hit_event,
	input logic miss_event
);

	logic wr_fire;
	logic rd_fire;
	logic ctrl_wr;
	word_t hit_count;
	word_t miss_count;
	word_t rd_value;

	assign s_bresp = 2'b00;
	assign s_rresp = 2'b00;

	assign wr_fire = s_awvalid && s_awready && s_wvalid && s_wready;
	assign rd_fire = s_arvalid && s_arready;
	assign ctrl_wr = wr_fire && s_wstrb[0] && (s_awaddr == csr_ctrl_off);

	////////////////////////////////////////////////////////////
	// bus handshakes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			s_awready <= 1'b0;
			s_wready <= 1'b0;
			s_bvalid <= 1'b0;
			s_arready <= 1'b0;
			s_rvalid <= 1'b0;
		end else begin
			// both ready lines rise together once address and data are present
			s_awready <= s_awvalid && s_wvalid && !s_awready && !s_bvalid;
			s_wready <= s_awvalid && s_wvalid && !s_awready && !s_bvalid;
			if (wr_fire) begin
				s_bvalid <= 1'b1;
			end else if (s_bready) begin
				s_bvalid <= 1'b0;
			end
			s_arready <= s_arvalid && !s_arready && !s_rvalid;
			if (rd_fire) begin
				s_rvalid <= 1'b1;
			end else if (s_rready) begin
				s_rvalid <= 1'b0;
			end
		end
	end

	always_comb begin
		rd_value = '0;
		if (s_araddr == csr_ctrl_off) begin
			rd_value[ctrl_enable_bit] = cache_enable;
		end else if (s_araddr == csr_hit_off) begin
			rd_value = hit_count;
		end else if (s_araddr == csr_miss_off) begin
			rd_value = miss_count;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			s_rdata <= rd_value;
		end
	end

	////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			cache_enable <= 1'b1;
			inval_pulse <= 1'b0;
			hit_count <= '0;
			miss_count <= '0;
		end else begin
			// the invalidate bit never stores, it only fires for one cycle
			inval_pulse <= ctrl_wr && s_wdata[ctrl_inval_bit];
			if (ctrl_wr) begin
				cache_enable <= s_wdata[ctrl_enable_bit];
			end
			if (wr_fire && (s_wstrb != '0) && (s_awaddr == csr_hit_off)) begin
				hit_count <= '0;
			end else if (hit_event && cache_enable) begin
				hit_count <= hit_count + 32'd1;
			end
			if (wr_fire && (s_wstrb != '0) && (s_awaddr == csr_miss_off)) begin
				miss_count <= '0;
			end else if (miss_event && cache_enable) begin
				miss_count <= miss_count + 32'd1;
			end
		end
	end

endmodule

// File: hw/icache_top.sv
module icache_top
	import icache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic fetch_valid,
	input addr_t fetch_addr,
	output logic fetch_ready,
	output logic rsp_valid,
	output word_t rsp_inst,
	input logic rsp_ready,
	output addr_t m_araddr,
	output logic m_arvalid,
	input logic m_arready,
	input word_t m_rdata,
	input logic [1:0] m_rresp,
	input logic m_rvalid,
	output logic m_rready,
	input addr_t s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input word_t s_wdata,
	input logic [3:0] s_wstrb,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input addr_t s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output word_t s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready
);

	index_t lookup_index;
	tag_t lookup_tag;
	way_mask_t way_hit;
	way_mask_t victim;
	way_mask_t sram_en;
	logic alloc;
	logic sram_we;
	line_t sram_rdata [num_ways];
	logic refill_start;
	addr_t refill_addr;
	logic refill_line_mode;
	logic refill_done;
	line_t refill_line;
	word_t refill_word;
	logic cache_enable;
	logic inval_pulse;
	logic hit_event;
	logic miss_event;

	icache_ctrl i_ctrl (
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.fetch_ready(fetch_ready),
		.rsp_valid(rsp_valid),
		.rsp_inst(rsp_inst),
		.rsp_ready(rsp_ready),
		.cache_enable(cache_enable),
		.lookup_index(lookup_index),
		.lookup_tag(lookup_tag),
		.way_hit(way_hit),
		.victim(victim),
		.alloc(alloc),
		.sram_en(sram_en),
		.sram_we(sram_we),
		.sram_rdata0(sram_rdata[0]),
		.sram_rdata1(sram_rdata[1]),
		.sram_rdata2(sram_rdata[2]),
		.sram_rdata3(sram_rdata[3]),
		.refill_start(refill_start),
		.refill_addr(refill_addr),
		.refill_line_mode(refill_line_mode),
		.refill_done(refill_done),
		.refill_line(refill_line),
		.refill_word(refill_word),
		.hit_event(hit_event),
		.miss_event(miss_event)
	);

	icache_tag_array i_tag_array (
		.clk(clk),
		.rst(rst),
		.lookup_index(lookup_index),
		.lookup_tag(lookup_tag),
		.alloc(alloc),
		.inval_pulse(inval_pulse),
		.way_hit(way_hit),
		.victim(victim)
	);

	// one data SRAM per way, all sharing the index and the refill line
	for (genvar w = 0; w < num_ways; w++) begin : g_way
		icache_data_sram i_sram (
			.clk(clk),
			.en(sram_en[w]),
			.we(sram_we),
			.index(lookup_index),
			.wdata(refill_line),
			.rdata(sram_rdata[w])
		);
	end

	icache_refill i_refill (
		.clk(clk),
		.rst(rst),
		.refill_start(refill_start),
		.refill_addr(refill_addr),
		.refill_line_mode(refill_line_mode),
		.refill_done(refill_done),
		.refill_line(refill_line),
		.refill_word(refill_word),
		.m_araddr(m_araddr),
		.m_arvalid(m_arvalid),
		.m_arready(m_arready),
		.m_rdata(m_rdata),
		.m_rresp(m_rresp),
		.m_rvalid(m_rvalid),
		.m_rready(m_rready)
	);

	icache_csr i_csr (
		.clk(clk),
		.rst(rst),
		.s_awaddr(s_awaddr),
		.s_awvalid(s_awvalid),
		.s_awready(s_awready),
		.s_wdata(s_wdata),
		.s_wstrb(s_wstrb),
		.s_wvalid(s_wvalid),
		.s_wready(s_wready),
		.s_bresp(s_bresp),
		.s_bvalid(s_bvalid),
		.s_bready(s_bready),
		.s_araddr(s_araddr),
		.s_arvalid(s_arvalid),
		.s_arready(s_arready),
		.s_rdata(s_rdata),
		.s_rresp(s_rresp),
		.s_rvalid(s_rvalid),
		.s_rready(s_rready),
		.cache_enable(cache_enable),
		.inval_pulse(inval_pulse),
		.hit_event(hit_event),
		.miss_event(miss_event)
	);

endmodule

// File: dv/icache_mem_model.sv
module icache_mem_model
	import icache_pkg::*;
(
	input logic clk,
	input logic rst,
	input addr_t araddr,
	input logic arvalid,
	output logic arready,
	output word_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	integer seed = 32'hf2893b28;
	int delay;
	addr_t addr;

	// every word reads back as its own address scrambled with a fixed mask
	initial begin
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rresp = 2'b00;
		forever begin
			if (rst || !arvalid) begin
				@(negedge clk);
			end else begin
				delay = $random(seed) & 3;
				repeat (delay) @(negedge clk);
				addr = araddr;
				arready = 1'b1;
				@(negedge clk);
				arready = 1'b0;
				delay = $random(seed) & 3;
				repeat (delay) @(negedge clk);
				while (!rready) begin
					@(negedge clk);
				end
				rdata = {addr[31:2], 2'b00} ^ 32'h5a5a_c3c3;
				rvalid = 1'b1;
				@(negedge clk);
				rvalid = 1'b0;
			end
		end
	end

endmodule

// File: dv/icache_tb.sv
module icache_tb
	import icache_pkg::*;
();

	// the longest phase is the random run, about 200 fetches at up to ~40 cycles a miss
	localparam int max_cycles = 20000;

	logic clk = 1'b0;
	logic rst;
	logic fetch_valid;
	addr_t fetch_addr;
	logic fetch_ready;
	logic rsp_valid;
	word_t rsp_inst;
	logic rsp_ready;
	addr_t m_araddr;
	logic m_arvalid;
	logic m_arready;
	word_t m_rdata;
	logic [1:0] m_rresp;
	logic m_rvalid;
	logic m_rready;
	addr_t s_awaddr;
	logic s_awvalid;
	logic s_awready;
	word_t s_wdata;
	logic [3:0] s_wstrb;
	logic s_wvalid;
	logic s_wready;
	logic [1:0] s_bresp;
	logic s_bvalid;
	logic s_bready;
	addr_t s_araddr;
	logic s_arvalid;
	logic s_arready;
	word_t s_rdata;
	logic [1:0] s_rresp;
	logic s_rvalid;
	logic s_rready;

	integer seed = 32'hf2893b28;
	// rsp_ready gets its own stream so process order cannot shift the address sequence
	integer ready_seed = 32'hf2893b28 ^ 32'h0000_ffff;
	word_t exp_q [$];
	word_t exp_word;
	int accept_count = 0;
	int ar_count = 0;
	int cycle_count = 0;
	int last_wait;
	int exp_hits = 0;
	int exp_misses = 0;
	logic ready_random = 1'b0;
	logic held = 1'b0;
	word_t held_inst;

	always #4 clk = ~clk;

	icache_top i_dut (.*);

	icache_mem_model i_mem (
		.clk(clk),
		.rst(rst),
		.araddr(m_araddr),
		.arvalid(m_arvalid),
		.arready(m_arready),
		.rdata(m_rdata),
		.rresp(m_rresp),
		.rvalid(m_rvalid),
		.rready(m_rready)
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else report_failure($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
	endtask

	function automatic word_t expected_word(input addr_t a);
		return {a[31:2], 2'b00} ^ 32'h5a5a_c3c3;
	endfunction

	function automatic addr_t line_base(input tag_t t, input index_t i);
		return {t, i, 4'b0000};
	endfunction

	// eight lines over two sets, four tags each, so the ring evicts during the run
	function automatic addr_t stress_line(input int k);
		return line_base(tag_t'(32'h100 + k), index_t'(12 + (k % 2)));
	endfunction

	////////////////////////////////////////////////////////////
	// monitors and checks
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			report_failure($sformatf("timeout: the run did not end within %0d cycles", max_cycles));
		end
	end

	always @(posedge clk) begin
		if (!rst && m_arvalid && m_arready) begin
			ar_count <= ar_count + 1;
		end
	end

	// requests queue their expected word, responses must come back in the same order
	always @(posedge clk) begin
		if (!rst) begin
			if (fetch_valid && fetch_ready) begin
				exp_q.push_back(expected_word(fetch_addr));
				accept_count <= accept_count + 1;
			end
			if (rsp_valid && rsp_ready) begin
				if (exp_q.size() == 0) begin
					report_failure("a response arrived with no fetch outstanding");
				end else begin
					exp_word = exp_q.pop_front();
					check_equal("rsp_inst", rsp_inst, exp_word);
				end
			end
		end
	end

	always @(posedge clk) begin
		if (!rst) begin
			if (held) begin
				assert (rsp_valid && rsp_inst === held_inst)
				else report_failure($sformatf("[FAIL] rsp_inst held at %h became %h, rsp_valid %h",
					held_inst, rsp_inst, rsp_valid));
			end
			held <= rsp_valid && !rsp_ready;
			held_inst <= rsp_inst;
		end
	end

	a_held_blocks_fetch: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |-> !fetch_ready)
		else report_failure($sformatf("[FAIL] fetch_ready is %h while a response is held",
			fetch_ready));

	a_one_ar_phase: assert property (@(posedge clk) disable iff (rst)
		m_rready |-> !m_arvalid)
		else report_failure($sformatf("[FAIL] m_arvalid is %h while m_rready is high", m_arvalid));

	always @(negedge clk) begin
		if (ready_random) begin
			rsp_ready = ($random(ready_seed) & 3) != 0;
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus tasks, all entered and left on a falling edge
	////////////////////////////////////////////////////////////

	task automatic fetch(input addr_t a);
		int start;
		start = accept_count;
		fetch_valid = 1'b1;
		fetch_addr = a;
		@(negedge clk);
		last_wait = 1;
		while (accept_count == start) begin
			@(negedge clk);
			last_wait++;
		end
		fetch_valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic fetch_checked(input addr_t a, input int exp_ar);
		int ar_before;
		ar_before = ar_count;
		fetch(a);
		drain();
		check_equal("m_ar handshakes", ar_count - ar_before, exp_ar);
	endtask

	task automatic expect_hit(input addr_t a);
		fetch_checked(a, 0);
		exp_hits++;
	endtask

	// a cached miss always refills the whole line
	task automatic expect_miss(input addr_t a);
		fetch_checked(a, line_words);
		exp_misses++;
	endtask

	task automatic csr_write(input addr_t a, input word_t d);
		s_awaddr = a;
		s_awvalid = 1'b1;
		s_wdata = d;
		s_wstrb = 4'hf;
		s_wvalid = 1'b1;
		@(negedge clk);
		while (!s_awready) begin
			@(negedge clk);
		end
		check_equal("s_wready", s_wready, 1);
		@(negedge clk);
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		check_equal("s_bvalid", s_bvalid, 1);
		check_equal("s_bresp", s_bresp, 0);
		while (s_bvalid) begin
			@(negedge clk);
		end
	endtask

	task automatic csr_read(input addr_t a, output word_t d);
		s_araddr = a;
		s_arvalid = 1'b1;
		@(negedge clk);
		while (!s_arready) begin
			@(negedge clk);
		end
		@(negedge clk);
		s_arvalid = 1'b0;
		check_equal("s_rvalid", s_rvalid, 1);
		check_equal("s_rresp", s_rresp, 0);
		d = s_rdata;
		while (s_rvalid) begin
			@(negedge clk);
		end
	endtask

	task automatic check_counters();
		word_t value;
		csr_read(csr_hit_off, value);
		check_equal("hit counter", value, exp_hits);
		csr_read(csr_miss_off, value);
		check_equal("miss counter", value, exp_misses);
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		word_t value;
		addr_t line_a;
		addr_t line_b;
		int k;
		int w;
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		rsp_ready = 1'b1;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wstrb = '0;
		s_wvalid = 1'b0;
		s_bready = 1'b1;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// reset state
		check_equal("rsp_valid", rsp_valid, 0);
		check_equal("m_arvalid", m_arvalid, 0);
		csr_read(csr_ctrl_off, value);
		check_equal("ctrl register", value, 1);
		check_counters();

		// one refill, then the rest of the line hits
		line_a = line_base(tag_t'(1), index_t'(3));
		expect_miss(line_a + 4);
		expect_hit(line_a);
		expect_hit(line_a + 8);
		expect_hit(line_a + 12);
		check_counters();

		// five tags in one set push the first one out of a four-way set
		for (k = 0; k < 5; k++) begin
			expect_miss(line_base(tag_t'(10 + k), index_t'(5)));
		end
		expect_miss(line_base(tag_t'(10), index_t'(5)));
		expect_hit(line_base(tag_t'(14), index_t'(5)));
		check_counters();

		// invalidate all, keeping the cache enabled
		csr_write(csr_ctrl_off, 32'h3);
		expect_miss(line_base(tag_t'(14), index_t'(5)));
		check_counters();

		// uncached fetches read one word each and allocate nothing
		csr_write(csr_ctrl_off, 32'h0);
		csr_read(csr_ctrl_off, value);
		check_equal("ctrl register", value, 0);
		line_b = line_base(tag_t'(20), index_t'(7));
		for (w = 0; w < line_words; w++) begin
			fetch_checked(line_b + 4 * w, 1);
		end
		check_counters();
		csr_write(csr_ctrl_off, 32'h1);
		expect_miss(line_b + 8);
		check_counters();

		// random run with back-pressure on the response
		ready_random = 1'b1;
		for (int n = 0; n < 200; n++) begin
			k = $random(seed) & 7;
			w = $random(seed) & 3;
			fetch(stress_line(k) + 4 * w);
			if (($random(seed) & 3) == 0) begin
				@(negedge clk);
			end
		end
		drain();
		ready_random = 1'b0;
		rsp_ready = 1'b1;
		@(negedge clk);

		// with the line resident every word must be accepted on the next edge
		for (k = 0; k < 8; k++) begin
			fetch(stress_line(k));
			drain();
			for (w = 0; w < line_words; w++) begin
				fetch(stress_line(k) + 4 * w);
				check_equal("fetch accept wait", last_wait, 1);
			end
			drain();
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

// File: compile.f
hw/icache_pkg.sv
hw/icache_data_sram.sv
hw/icache_tag_array.sv
hw/icache_refill.sv
hw/icache_ctrl.sv
hw/icache_csr.sv
hw/icache_top.sv
dv/icache_mem_model.sv
dv/icache_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the result from the log
verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
	-f compile.f -o icache_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/icache_sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0
